/* src/core_params.svh */
// Core memory monitor parameters
// Lane count, counter width and DCR bus widths shared by packages and RTL

`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Number of data cache lanes observed by the monitor
`define DCACHE_NUM_REQS 4

// Width of every performance counter
`define PERF_CTR_BITS 44

// DCR write bus widths
`define DCR_ADDR_WIDTH 12
`define DCR_DATA_WIDTH 32

`endif

/* src/dcr_pkg.sv */
// Device configuration register definitions
// Base register addresses, the DCR write word and the base register set

`include "core_params.svh"

package dcr_pkg;

    // Base register addresses
    localparam logic [`DCR_ADDR_WIDTH-1:0] DCR_STARTUP_ADDR0 = 'h001;
    localparam logic [`DCR_ADDR_WIDTH-1:0] DCR_STARTUP_ADDR1 = 'h002;
    localparam logic [`DCR_ADDR_WIDTH-1:0] DCR_MPM_CLASS     = 'h003;

    // External DCR write, taken when valid is high
    typedef struct packed {
        logic                       valid;
        logic [`DCR_ADDR_WIDTH-1:0] addr;
        logic [`DCR_DATA_WIDTH-1:0] data;
    } dcr_write_t;

    // Current base configuration of the core
    typedef struct packed {
        logic [`DCR_DATA_WIDTH-1:0] startup_addr0;
        logic [`DCR_DATA_WIDTH-1:0] startup_addr1;
        logic [7:0]                 mpm_class;
    } base_dcrs_t;

endpackage

/* src/perf_pkg.sv */
// Memory performance monitor types
// Bus probe, counter word and counter select encoding

`include "core_params.svh"

package perf_pkg;

    // Observed handshake signals of one memory lane
    // A request or response fires when its valid and ready are both high
    typedef struct packed {
        logic req_valid;
        logic req_ready;
        logic req_rw;
        logic rsp_valid;
        logic rsp_ready;
    } bus_probe_t;

    // One performance counter word
    typedef logic [`PERF_CTR_BITS-1:0] perf_ctr_t;

    // Counter select, other encodings read as zero
    typedef enum logic [2:0] {
        IFETCHES       = 3'd0,
        LOADS          = 3'd1,
        STORES         = 3'd2,
        IFETCH_LATENCY = 3'd3,
        LOAD_LATENCY   = 3'd4
    } perf_sel_e;

endpackage

/* src/dcr_regs.sv */
// DCR base registers
// Decodes DCR writes into the startup addresses and the MPM class

`timescale 1ns/1ps

module dcr_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  dcr_pkg::dcr_write_t    dcr_write,
    output dcr_pkg::base_dcrs_t    base_dcrs
);

    always_ff @(posedge clk) begin
        if (reset) begin
            base_dcrs <= '0;
        end else if (dcr_write.valid) begin
            case (dcr_write.addr)
                dcr_pkg::DCR_STARTUP_ADDR0: begin
                    base_dcrs.startup_addr0 <= dcr_write.data;
                end
                dcr_pkg::DCR_STARTUP_ADDR1: begin
                    base_dcrs.startup_addr1 <= dcr_write.data;
                end
                dcr_pkg::DCR_MPM_CLASS: begin
                    // Only the low byte is kept
                    base_dcrs.mpm_class <= dcr_write.data[7:0];
                end
                default: begin
                    // Unknown address, nothing changes
                end
            endcase
        end
    end

endmodule

/* src/mem_traffic_counter.sv */
// Memory traffic counter
// Counts read and write request fires over N lanes of one memory port
// and accumulates the number of outstanding reads per cycle as latency

`timescale 1ns/1ps

`include "core_params.svh"

module mem_traffic_counter #(
    parameter int NUM_LANES = 1
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  perf_pkg::bus_probe_t [NUM_LANES-1:0] probe,
    output perf_pkg::perf_ctr_t                  reads,
    output perf_pkg::perf_ctr_t                  writes,
    output perf_pkg::perf_ctr_t                  read_latency
);

    localparam int CNT_W = $clog2(NUM_LANES + 1);

    logic [CNT_W-1:0]                 rd_fires;
    logic [CNT_W-1:0]                 wr_fires;
    logic [CNT_W-1:0]                 rsp_fires;
    logic signed [`PERF_CTR_BITS-1:0] pending_delta;
    logic signed [`PERF_CTR_BITS-1:0] pending_reads;

    // Per cycle fire counts across all lanes
    always_comb begin
        rd_fires  = '0;
        wr_fires  = '0;
        rsp_fires = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (probe[i].req_valid && probe[i].req_ready) begin
                if (probe[i].req_rw) begin
                    wr_fires = wr_fires + CNT_W'(1);
                end else begin
                    rd_fires = rd_fires + CNT_W'(1);
                end
            end
            if (probe[i].rsp_valid && probe[i].rsp_ready) begin
                rsp_fires = rsp_fires + CNT_W'(1);
            end
        end
    end

    // Net change of outstanding reads, may be negative
    assign pending_delta = `PERF_CTR_BITS'(rd_fires) - `PERF_CTR_BITS'(rsp_fires);

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_reads <= '0;
        end else begin
            pending_reads <= pending_reads + pending_delta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            reads        <= '0;
            writes       <= '0;
            read_latency <= '0;
        end else begin
            reads        <= reads + perf_pkg::perf_ctr_t'(rd_fires);
            writes       <= writes + perf_pkg::perf_ctr_t'(wr_fires);
            // Uses the count from before this edge
            read_latency <= read_latency + perf_pkg::perf_ctr_t'(pending_reads);
        end
    end

endmodule

/* src/perf_readout.sv */
// Performance counter readout
// Registers the counter selected by the read address

`timescale 1ns/1ps

module perf_readout (
    input  logic                clk,
    input  logic                reset,
    input  perf_pkg::perf_ctr_t ifetches,
    input  perf_pkg::perf_ctr_t loads,
    input  perf_pkg::perf_ctr_t stores,
    input  perf_pkg::perf_ctr_t ifetch_latency,
    input  perf_pkg::perf_ctr_t load_latency,
    input  perf_pkg::perf_sel_e perf_read_addr,
    output perf_pkg::perf_ctr_t perf_read_data
);

    perf_pkg::perf_ctr_t sel_data;

    always_comb begin
        case (perf_read_addr)
            perf_pkg::IFETCHES:       sel_data = ifetches;
            perf_pkg::LOADS:          sel_data = loads;
            perf_pkg::STORES:         sel_data = stores;
            perf_pkg::IFETCH_LATENCY: sel_data = ifetch_latency;
            perf_pkg::LOAD_LATENCY:   sel_data = load_latency;
            // Unused index
            default:                  sel_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            perf_read_data <= '0;
        end else begin
            perf_read_data <= sel_data;
        end
    end

endmodule

/* src/core_top.sv */
// Core memory performance monitor top level
// Holds the DCR base registers, taps the icache and dcache ports
// and exposes the traffic counters through a registered readout

`timescale 1ns/1ps

`include "core_params.svh"

module core_top (
    input  logic                                        clk,
    input  logic                                        reset,
    input  dcr_pkg::dcr_write_t                         dcr_write,
    input  perf_pkg::bus_probe_t                        icache_probe,
    input  perf_pkg::bus_probe_t [`DCACHE_NUM_REQS-1:0] dcache_probe,
    input  perf_pkg::perf_sel_e                         perf_read_addr,
    output dcr_pkg::base_dcrs_t                         base_dcrs,
    output perf_pkg::perf_ctr_t                         perf_read_data
);

    perf_pkg::perf_ctr_t ifetches;
    perf_pkg::perf_ctr_t ifetch_latency;
    perf_pkg::perf_ctr_t loads;
    perf_pkg::perf_ctr_t stores;
    perf_pkg::perf_ctr_t load_latency;

    dcr_regs dcr_regs_i (
        .clk       (clk),
        .reset     (reset),
        .dcr_write (dcr_write),
        .base_dcrs (base_dcrs)
    );

    // Instruction fetches are the icache read fires
    mem_traffic_counter #(
        .NUM_LANES (1)
    ) icache_ctr (
        .clk          (clk),
        .reset        (reset),
        .probe        (icache_probe),
        .reads        (ifetches),
        .writes       (),
        .read_latency (ifetch_latency)
    );

    mem_traffic_counter #(
        .NUM_LANES (`DCACHE_NUM_REQS)
    ) dcache_ctr (
        .clk          (clk),
        .reset        (reset),
        .probe        (dcache_probe),
        .reads        (loads),
        .writes       (stores),
        .read_latency (load_latency)
    );

    perf_readout perf_readout_i (
        .clk            (clk),
        .reset          (reset),
        .ifetches       (ifetches),
        .loads          (loads),
        .stores         (stores),
        .ifetch_latency (ifetch_latency),
        .load_latency   (load_latency),
        .perf_read_addr (perf_read_addr),
        .perf_read_data (perf_read_data)
    );

endmodule

/* tests/core_top_asserts.sv */
// Concurrent checks on the monitor top level
// Readout reset value, base register stability and fetch count order

`timescale 1ns/1ps

module core_top_asserts (
    input logic                clk,
    input logic                reset,
    input dcr_pkg::dcr_write_t dcr_write,
    input dcr_pkg::base_dcrs_t base_dcrs,
    input perf_pkg::perf_ctr_t perf_read_data,
    input perf_pkg::perf_ctr_t ifetches
);

    int assert_errors = 0;

    readout_cleared: assert property (@(posedge clk) $past(reset) |-> perf_read_data == '0)
        else begin
            $error("perf_read_data is not zero in the cycle after reset");
            assert_errors++;
        end

    // Base registers only move on a DCR write
    base_stable: assert property (@(posedge clk) disable iff (reset)
        (!$past(dcr_write.valid) && !$past(reset)) |-> $stable(base_dcrs))
        else begin
            $error("base_dcrs changed without a DCR write");
            assert_errors++;
        end

    ifetch_monotonic: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> ifetches >= $past(ifetches))
        else begin
            $error("IFETCHES counter decreased");
            assert_errors++;
        end

endmodule

bind core_top core_top_asserts asserts_i (
    .clk            (clk),
    .reset          (reset),
    .dcr_write      (dcr_write),
    .base_dcrs      (base_dcrs),
    .perf_read_data (perf_read_data),
    .ifetches       (ifetches)
);

/* tests/tb_core_top.sv */
// Testbench for the core memory performance monitor
// Replays DCR writes and bus cycles from a cases file and checks
// the counter readout and the base registers against expected values

`timescale 1ns/1ps

`include "core_params.svh"

module tb_core_top;

    localparam int    CLK_PERIOD = 10;
    localparam string CASES_FILE = "tests/core_cases.txt";

    logic                                        clk;
    logic                                        reset;
    dcr_pkg::dcr_write_t                         dcr_write;
    perf_pkg::bus_probe_t                        icache_probe;
    perf_pkg::bus_probe_t [`DCACHE_NUM_REQS-1:0] dcache_probe;
    perf_pkg::perf_sel_e                         perf_read_addr;
    dcr_pkg::base_dcrs_t                         base_dcrs;
    perf_pkg::perf_ctr_t                         perf_read_data;

    int total_lines   = 0;
    bit lines_counted = 1'b0;
    int pass_count    = 0;
    int fail_count    = 0;
    int case_num      = 0;

    core_top UUT (
        .clk            (clk),
        .reset          (reset),
        .dcr_write      (dcr_write),
        .icache_probe   (icache_probe),
        .dcache_probe   (dcache_probe),
        .perf_read_addr (perf_read_addr),
        .base_dcrs      (base_dcrs),
        .perf_read_data (perf_read_data)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Inputs change 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_idle();
        dcr_write    = '0;
        icache_probe = '0;
        dcache_probe = '0;
    endtask

    function automatic string counter_name(input int idx);
        case (idx)
            0:       return "IFETCHES";
            1:       return "LOADS";
            2:       return "STORES";
            3:       return "IFETCH_LATENCY";
            4:       return "LOAD_LATENCY";
            default: return "UNUSED";
        endcase
    endfunction

    task automatic check_counter(input int idx, input perf_pkg::perf_ctr_t expected);
        drive_idle();
        perf_read_addr = perf_pkg::perf_sel_e'(idx[2:0]);
        step_cycle();
        step_cycle();
        case_num++;
        if (perf_read_data !== expected) begin
            $display("FAILED t=%0t perf_read_data[%s] got %0h expected %0h",
                     $time, counter_name(idx), perf_read_data, expected);
            fail_count++;
        end else begin
            $display("case %0d ok  %s = %0h", case_num, counter_name(idx), expected);
            pass_count++;
        end
    endtask

    task automatic check_base(input dcr_pkg::base_dcrs_t expected);
        drive_idle();
        case_num++;
        if (base_dcrs !== expected) begin
            $display("FAILED t=%0t base_dcrs got %h expected %h", $time, base_dcrs, expected);
            fail_count++;
        end else begin
            $display("case %0d ok  base_dcrs = %h", case_num, expected);
            pass_count++;
        end
    endtask

    task automatic pulse_reset();
        drive_idle();
        reset = 1'b1;
        repeat (3) step_cycle();
        reset = 1'b0;
    endtask

    // Idle cycles between cases while no read is outstanding
    task automatic idle_gap();
        drive_idle();
        repeat ($urandom % 4) step_cycle();
    endtask

    task automatic report_bad_line(input string line);
        $display("Cannot parse line of the cases file: %s", line);
        fail_count++;
    endtask

    initial begin : main
        int                         fd;
        int                         n;
        int                         idx;
        string                      line;
        byte                        kind;
        logic [4:0]                 ic;
        logic [4:0]                 d0;
        logic [4:0]                 d1;
        logic [4:0]                 d2;
        logic [4:0]                 d3;
        logic [`DCR_ADDR_WIDTH-1:0] addr;
        logic [`DCR_DATA_WIDTH-1:0] data;
        logic [`DCR_DATA_WIDTH-1:0] a0;
        logic [`DCR_DATA_WIDTH-1:0] a1;
        logic [7:0]                 cls;
        perf_pkg::perf_ctr_t        value;

        void'($urandom(93));
        reset          = 1'b1;
        perf_read_addr = perf_pkg::IFETCHES;
        drive_idle();

        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the cases file %s", CASES_FILE);
            fail_count++;
        end else begin
            // First pass sizes the watchdog
            while ($fgets(line, fd) != 0) begin
                total_lines++;
            end
            lines_counted = 1'b1;
            $fclose(fd);
            fd = $fopen(CASES_FILE, "r");

            repeat (10) @(posedge clk);
            #1;
            reset = 1'b0;

            while ($fgets(line, fd) != 0) begin
                kind = line.getc(0);
                case (kind)
                    "W": begin
                        n = $sscanf(line, "W %h %h", addr, data);
                        if (n != 2) begin
                            report_bad_line(line);
                        end else begin
                            drive_idle();
                            dcr_write.valid = 1'b1;
                            dcr_write.addr  = addr;
                            dcr_write.data  = data;
                            step_cycle();
                        end
                    end
                    "B": begin
                        n = $sscanf(line, "B %b %b %b %b %b", ic, d0, d1, d2, d3);
                        if (n != 5) begin
                            report_bad_line(line);
                        end else begin
                            drive_idle();
                            icache_probe    = ic;
                            dcache_probe[0] = d0;
                            dcache_probe[1] = d1;
                            dcache_probe[2] = d2;
                            dcache_probe[3] = d3;
                            step_cycle();
                        end
                    end
                    "C": begin
                        n = $sscanf(line, "C %d %h", idx, value);
                        if (n != 2) begin
                            report_bad_line(line);
                        end else begin
                            check_counter(idx, value);
                            idle_gap();
                        end
                    end
                    "D": begin
                        n = $sscanf(line, "D %h %h %h", a0, a1, cls);
                        if (n != 3) begin
                            report_bad_line(line);
                        end else begin
                            check_base(dcr_pkg::base_dcrs_t'({a0, a1, cls}));
                            idle_gap();
                        end
                    end
                    "R": begin
                        pulse_reset();
                    end
                    "#", 8'h0a, 8'h0d, 8'h20, 8'h00: begin
                        // Comment or blank line
                    end
                    default: begin
                        report_bad_line(line);
                    end
                endcase
            end
            $fclose(fd);
            drive_idle();
            step_cycle();

            if (case_num == 0) begin
                $display("No checks were found in the cases file");
                fail_count++;
            end
        end

        $display("checks: %0d passed, %0d failed, %0d assertion errors",
                 pass_count, fail_count, UUT.asserts_i.assert_errors);
        if (fail_count == 0 && UUT.asserts_i.assert_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Generous bound of 20 cycles per line of the cases file
    initial begin : watchdog
        wait (lines_counted);
        #(total_lines * 20 * CLK_PERIOD);
        $display("Watchdog expired before the cases file was finished");
        $display("Verification failed");
        $finish;
    end

endmodule

/* tests/core_cases.txt */
# W addr data | B icache lane0 lane1 lane2 lane3, each vld rdy rw rspv rspr in binary
# C counter index (decimal) value | D startup_addr0 startup_addr1 mpm_class | R reset pulse
W 001 80000000
W 002 80001000
W 003 000001a5
W 7ff deadbeef
D 80000000 80001000 a5
B 11000 00000 00000 00000 00000
B 10000 00000 00000 00000 00000
B 00011 00000 00000 00000 00000
C 0 1
C 3 2
B 00000 11000 11100 11000 11100
B 11100 11000 00000 00011 00000
B 00000 00000 00000 00000 10100
B 00000 00011 00000 00011 00000
C 1 3
C 2 2
C 4 6
C 0 1
C 3 2
C 5 0
C 7 0
B 11000 00000 00000 00000 00000
B 11000 00000 00000 00000 00000
B 00011 00000 00000 00000 00000
B 00011 00000 00000 00000 00000
C 0 3
C 3 6
R
C 0 0
C 3 0
C 4 0
D 00000000 00000000 00
B 00000 11000 00000 00000 00000
B 00000 00011 00000 00000 00000
C 1 1
C 4 1

/* vlog.f */
+incdir+src
src/dcr_pkg.sv
src/perf_pkg.sv
src/dcr_regs.sv
src/mem_traffic_counter.sv
src/perf_readout.sv
src/core_top.sv
tests/core_top_asserts.sv
tests/tb_core_top.sv

/* Bender.yml */
package:
  name: core_perf_monitor

sources:
  - include_dirs:
      - src
    files:
      - src/dcr_pkg.sv
      - src/perf_pkg.sv
      - src/dcr_regs.sv
      - src/mem_traffic_counter.sv
      - src/perf_readout.sv
      - src/core_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/core_top_asserts.sv
      - tests/tb_core_top.sv
